//--- rv32i_types.sv
`default_nettype none

package rv32i_types;

	typedef logic [31:0] rv32i_word;

	// ------------------------------------------------------------
	// Major opcodes
	// ------------------------------------------------------------
	typedef enum logic [6:0] {
		op_reg      = 7'b0110011,
		op_imm      = 7'b0010011,
		op_lui      = 7'b0110111,
		op_auipc    = 7'b0010111,
		op_jal      = 7'b1101111,
		op_jalr     = 7'b1100111,
		op_br       = 7'b1100011,
		op_load     = 7'b0000011,
		op_store    = 7'b0100011,
		op_misc_mem = 7'b0001111,
		op_system   = 7'b1110011
	} rv32i_opcode_t;

	// ------------------------------------------------------------
	// Function codes
	// ------------------------------------------------------------
	localparam logic [2:0] f3_add_sub = 3'b000;
	localparam logic [2:0] f3_sll     = 3'b001;
	localparam logic [2:0] f3_slt     = 3'b010;
	localparam logic [2:0] f3_sltu    = 3'b011;
	localparam logic [2:0] f3_xor     = 3'b100;
	localparam logic [2:0] f3_sr      = 3'b101; // srl or sra by funct7.
	localparam logic [2:0] f3_or      = 3'b110;
	localparam logic [2:0] f3_and     = 3'b111;

	localparam logic [2:0] f3_beq     = 3'b000;
	localparam logic [2:0] f3_bne     = 3'b001;
	localparam logic [2:0] f3_blt     = 3'b100;
	localparam logic [2:0] f3_bge     = 3'b101;
	localparam logic [2:0] f3_bltu    = 3'b110;
	localparam logic [2:0] f3_bgeu    = 3'b111;

	localparam logic [6:0] f7_alt     = 7'b0100000; // Selects sub and sra.

	typedef struct packed {
		rv32i_opcode_t opcode;
		logic [4:0]    rd;
		logic [4:0]    rs1;
		logic [4:0]    rs2;
		logic [2:0]    funct3;
		logic [6:0]    funct7;
		rv32i_word     imm;      // Sign-extended.
	} instruction_decoded_t;

endpackage : rv32i_types

`default_nettype wire

//--- rv32i_ctrl_pkg.sv
`default_nettype none

package rv32i_ctrl_pkg;

	// ------------------------------------------------------------
	// Control selects, all zero encodings form a no-op
	// ------------------------------------------------------------
	typedef enum logic [3:0] {
		alu_add    = 4'd0,
		alu_sub    = 4'd1,
		alu_sll    = 4'd2,
		alu_slt    = 4'd3,
		alu_sltu   = 4'd4,
		alu_xor    = 4'd5,
		alu_srl    = 4'd6,
		alu_sra    = 4'd7,
		alu_or     = 4'd8,
		alu_and    = 4'd9,
		alu_pass_b = 4'd10
	} alu_op_t;

	typedef enum logic [1:0] {src_a_rs1, src_a_pc, src_a_zero} alu_src_a_t;
	typedef enum logic {src_b_rs2, src_b_imm} alu_src_b_t;
	typedef enum logic [2:0] {br_none, br_cond, br_jal, br_jalr} branch_kind_t;
	typedef enum logic {res_alu, res_pc4} result_sel_t;

	typedef struct packed {
		alu_op_t      alu_op;
		alu_src_a_t   alu_src_a;
		alu_src_b_t   alu_src_b;
		branch_kind_t branch_kind;
		result_sel_t  result_sel;
		logic         reg_write;
	} rv32i_control_word;

	typedef struct packed {
		rv32i_types::rv32i_word pc;
		rv32i_types::rv32i_word result;      // Value for rd.
		logic [4:0]             rd;
		logic                   reg_write;
		logic                   redirect;
		rv32i_types::rv32i_word redirect_pc;
		logic                   halt;
	} ex_mem_t;

endpackage : rv32i_ctrl_pkg

`default_nettype wire

//--- id_decode.sv
`timescale 1ns/1ps
`default_nettype none

module id_decode
(
	input  rv32i_types::rv32i_word             instruction_i,
	output rv32i_types::instruction_decoded_t  decoded_o,
	output rv32i_ctrl_pkg::rv32i_control_word  control_o
);
	import rv32i_types::*;
	import rv32i_ctrl_pkg::*;

	// Shared by op and op_imm, alt picks sub or sra.
	function automatic alu_op_t alu_op_of(input logic [2:0] funct3, input logic alt);
		alu_op_t op;
		case (funct3)
			f3_add_sub: op = alt ? alu_sub : alu_add;
			f3_sll:     op = alu_sll;
			f3_slt:     op = alu_slt;
			f3_sltu:    op = alu_sltu;
			f3_xor:     op = alu_xor;
			f3_sr:      op = alt ? alu_sra : alu_srl;
			f3_or:      op = alu_or;
			f3_and:     op = alu_and;
			default:    op = alu_add;
		endcase
		return op;
	endfunction

	// ------------------------------------------------------------
	// Fields and immediate
	// ------------------------------------------------------------
	always_comb
	begin
		decoded_o.opcode = rv32i_opcode_t'(instruction_i[6:0]);
		decoded_o.rd     = instruction_i[11:7];
		decoded_o.funct3 = instruction_i[14:12];
		decoded_o.rs1    = instruction_i[19:15];
		decoded_o.rs2    = instruction_i[24:20];
		decoded_o.funct7 = instruction_i[31:25];
		case (decoded_o.opcode)
			op_imm, op_jalr, op_load, op_system:
				decoded_o.imm = {{20{instruction_i[31]}}, instruction_i[31:20]};
			op_store:
				decoded_o.imm = {{20{instruction_i[31]}}, instruction_i[31:25],
					instruction_i[11:7]};
			op_br:
				decoded_o.imm = {{19{instruction_i[31]}}, instruction_i[31], instruction_i[7],
					instruction_i[30:25], instruction_i[11:8], 1'b0};
			op_lui, op_auipc:
				decoded_o.imm = {instruction_i[31:12], 12'h000};
			op_jal:
				decoded_o.imm = {{11{instruction_i[31]}}, instruction_i[31],
					instruction_i[19:12], instruction_i[20], instruction_i[30:21], 1'b0};
			default:
				decoded_o.imm = '0;
		endcase
	end

	// ------------------------------------------------------------
	// Control word
	// ------------------------------------------------------------
	always_comb
	begin
		control_o = '0;
		case (decoded_o.opcode)
			op_reg:
			begin
				control_o.alu_op    = alu_op_of(decoded_o.funct3, decoded_o.funct7 == f7_alt);
				control_o.reg_write = 1'b1;
			end
			op_imm:
			begin
				control_o.alu_op    = alu_op_of(decoded_o.funct3,
					(decoded_o.funct3 == f3_sr) && (decoded_o.funct7 == f7_alt));
				control_o.alu_src_b = src_b_imm;
				control_o.reg_write = 1'b1;
			end
			op_lui:
			begin
				control_o.alu_op    = alu_pass_b;
				control_o.alu_src_b = src_b_imm;
				control_o.reg_write = 1'b1;
			end
			op_auipc:
			begin
				control_o.alu_src_a = src_a_pc;
				control_o.alu_src_b = src_b_imm;
				control_o.reg_write = 1'b1;
			end
			op_jal:
			begin
				control_o.branch_kind = br_jal;
				control_o.result_sel  = res_pc4;
				control_o.reg_write   = 1'b1;
			end
			op_jalr:
			begin
				control_o.branch_kind = br_jalr;
				control_o.result_sel  = res_pc4;
				control_o.reg_write   = 1'b1;
			end
			op_br:    control_o.branch_kind = br_cond;
			default:  control_o = '0; // Loads, stores, fence, system and unknown.
		endcase
		if (decoded_o.rd == 5'd0)
			control_o.reg_write = 1'b0; // x0 is hardwired.
	end

endmodule : id_decode

`default_nettype wire

//--- id_ex_regs.sv
`timescale 1ns/1ps
`default_nettype none

module id_ex_regs
(
	input  logic                               clk,
	input  logic                               rst,
	input  logic                               load_i,
	input  logic                               bubble_i,
	input  logic                               halt_i,
	input  rv32i_types::rv32i_word             pc_i,
	input  rv32i_types::rv32i_word             instruction_i,
	input  rv32i_types::rv32i_word             rs1_data_i,
	input  rv32i_types::rv32i_word             rs2_data_i,
	input  rv32i_types::instruction_decoded_t  decoded_i,
	input  rv32i_ctrl_pkg::rv32i_control_word  control_i,
	output rv32i_types::rv32i_word             pc_o,
	output rv32i_types::rv32i_word             instruction_o,
	output rv32i_types::rv32i_word             rs1_data_o,
	output rv32i_types::rv32i_word             rs2_data_o,
	output rv32i_types::instruction_decoded_t  decoded_o,
	output rv32i_ctrl_pkg::rv32i_control_word  control_o,
	output logic                               halt_o
);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			pc_o          <= '0;
			instruction_o <= '0;
			rs1_data_o    <= '0;
			rs2_data_o    <= '0;
			decoded_o     <= '0;
			control_o     <= '0;
			halt_o        <= halt_i; // Halt survives reset.
		end
		else if (load_i)
		begin
			pc_o   <= pc_i;
			halt_o <= halt_i;
			if (bubble_i)
			begin
				instruction_o <= '0; // Squash into a no-op.
				rs1_data_o    <= '0;
				rs2_data_o    <= '0;
				decoded_o     <= '0;
				control_o     <= '0;
			end
			else
			begin
				instruction_o <= instruction_i;
				rs1_data_o    <= rs1_data_i;
				rs2_data_o    <= rs2_data_i;
				decoded_o     <= decoded_i;
				control_o     <= control_i;
			end
		end
	end

endmodule : id_ex_regs

`default_nettype wire

//--- ex_alu.sv
`timescale 1ns/1ps
`default_nettype none

module ex_alu
(
	input  rv32i_types::rv32i_word             pc_i,
	input  rv32i_types::rv32i_word             rs1_data_i,
	input  rv32i_types::rv32i_word             rs2_data_i,
	input  rv32i_types::rv32i_word             imm_i,
	input  rv32i_ctrl_pkg::rv32i_control_word  control_i,
	output rv32i_types::rv32i_word             result_o
);
	import rv32i_types::*;
	import rv32i_ctrl_pkg::*;

	rv32i_word  operand_a;
	rv32i_word  operand_b;
	logic [4:0] shamt;

	always_comb
	begin
		case (control_i.alu_src_a)
			src_a_pc:   operand_a = pc_i;
			src_a_zero: operand_a = '0;
			default:    operand_a = rs1_data_i;
		endcase
		operand_b = (control_i.alu_src_b == src_b_imm) ? imm_i : rs2_data_i;
	end

	assign shamt = operand_b[4:0];

	always_comb
	begin
		case (control_i.alu_op)
			alu_add:    result_o = operand_a + operand_b;
			alu_sub:    result_o = operand_a - operand_b;
			alu_sll:    result_o = operand_a << shamt;
			alu_slt:    result_o = {31'd0, $signed(operand_a) < $signed(operand_b)};
			alu_sltu:   result_o = {31'd0, operand_a < operand_b};
			alu_xor:    result_o = operand_a ^ operand_b;
			alu_srl:    result_o = operand_a >> shamt;
			alu_sra:    result_o = rv32i_word'($signed(operand_a) >>> shamt);
			alu_or:     result_o = operand_a | operand_b;
			alu_and:    result_o = operand_a & operand_b;
			alu_pass_b: result_o = operand_b; // lui.
			default:    result_o = '0;
		endcase
	end

endmodule : ex_alu

`default_nettype wire

//--- ex_branch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module ex_branch_unit
(
	input  rv32i_types::rv32i_word        pc_i,
	input  rv32i_types::rv32i_word        rs1_data_i,
	input  rv32i_types::rv32i_word        rs2_data_i,
	input  rv32i_types::rv32i_word        imm_i,
	input  logic [2:0]                    funct3_i,
	input  rv32i_ctrl_pkg::branch_kind_t  branch_kind_i,
	output logic                          taken_o,
	output rv32i_types::rv32i_word        target_o
);
	import rv32i_types::*;
	import rv32i_ctrl_pkg::*;

	logic      cond_true;
	rv32i_word jalr_sum;

	always_comb
	begin
		case (funct3_i)
			f3_beq:  cond_true = rs1_data_i == rs2_data_i;
			f3_bne:  cond_true = rs1_data_i != rs2_data_i;
			f3_blt:  cond_true = $signed(rs1_data_i) < $signed(rs2_data_i);
			f3_bge:  cond_true = $signed(rs1_data_i) >= $signed(rs2_data_i);
			f3_bltu: cond_true = rs1_data_i < rs2_data_i;
			f3_bgeu: cond_true = rs1_data_i >= rs2_data_i;
			default: cond_true = 1'b0; // Reserved encodings.
		endcase
		case (branch_kind_i)
			br_cond:         taken_o = cond_true;
			br_jal, br_jalr: taken_o = 1'b1;
			default:         taken_o = 1'b0;
		endcase
	end

	assign jalr_sum = rs1_data_i + imm_i;
	assign target_o = (branch_kind_i == br_jalr) ? {jalr_sum[31:1], 1'b0} : pc_i + imm_i;

endmodule : ex_branch_unit

`default_nettype wire

//--- ex_mem_regs.sv
`timescale 1ns/1ps
`default_nettype none

module ex_mem_regs
(
	input  logic                               clk,
	input  logic                               rst,
	input  logic                               load_i,
	input  logic                               halt_i,
	input  rv32i_types::rv32i_word             pc_i,
	input  logic [4:0]                         rd_i,
	input  rv32i_ctrl_pkg::rv32i_control_word  control_i,
	input  rv32i_types::rv32i_word             alu_result_i,
	input  logic                               taken_i,
	input  rv32i_types::rv32i_word             target_i,
	output rv32i_ctrl_pkg::ex_mem_t            ex_mem_o
);
	import rv32i_ctrl_pkg::*;

	ex_mem_t record;

	// ------------------------------------------------------------
	// Execute record
	// ------------------------------------------------------------
	always_comb
	begin
		record.pc = pc_i;
		if (control_i.result_sel == res_pc4)
			record.result = pc_i + 32'd4; // Link address.
		else
			record.result = alu_result_i;
		record.rd          = rd_i;
		record.reg_write   = control_i.reg_write;
		record.redirect    = taken_i;
		record.redirect_pc = target_i;
		record.halt        = halt_i;
	end

	// ------------------------------------------------------------
	// EX/MEM register
	// ------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			ex_mem_o      <= '0;
			ex_mem_o.halt <= halt_i; // Carries the halt latched by ID/EX.
		end
		else if (load_i)
		begin
			ex_mem_o <= record;
		end
	end

endmodule : ex_mem_regs

`default_nettype wire

//--- id_ex_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module id_ex_pipe
(
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     load_i,
	input  logic                     bubble_i,
	input  logic                     halt_i,
	input  rv32i_types::rv32i_word   pc_i,
	input  rv32i_types::rv32i_word   instruction_i,
	input  rv32i_types::rv32i_word   rs1_data_i,
	input  rv32i_types::rv32i_word   rs2_data_i,
	output rv32i_ctrl_pkg::ex_mem_t  ex_mem_o
);
	import rv32i_types::*;
	import rv32i_ctrl_pkg::*;

	instruction_decoded_t id_decoded;
	rv32i_control_word    id_control;

	rv32i_word            ex_pc;
	rv32i_word            ex_rs1_data;
	rv32i_word            ex_rs2_data;
	instruction_decoded_t ex_decoded;
	rv32i_control_word    ex_control;
	logic                 ex_halt;
	rv32i_word            ex_alu_result;
	logic                 ex_taken;
	rv32i_word            ex_target;

	id_decode u_decode
	(
		.instruction_i (instruction_i),
		.decoded_o     (id_decoded),
		.control_o     (id_control)
	);

	id_ex_regs u_id_ex
	(
		.clk           (clk),
		.rst           (rst),
		.load_i        (load_i),
		.bubble_i      (bubble_i),
		.halt_i        (halt_i),
		.pc_i          (pc_i),
		.instruction_i (instruction_i),
		.rs1_data_i    (rs1_data_i),
		.rs2_data_i    (rs2_data_i),
		.decoded_i     (id_decoded),
		.control_i     (id_control),
		.pc_o          (ex_pc),
		.instruction_o (), // Raw word kept in the stage for debug only.
		.rs1_data_o    (ex_rs1_data),
		.rs2_data_o    (ex_rs2_data),
		.decoded_o     (ex_decoded),
		.control_o     (ex_control),
		.halt_o        (ex_halt)
	);

	ex_alu u_alu
	(
		.pc_i       (ex_pc),
		.rs1_data_i (ex_rs1_data),
		.rs2_data_i (ex_rs2_data),
		.imm_i      (ex_decoded.imm),
		.control_i  (ex_control),
		.result_o   (ex_alu_result)
	);

	ex_branch_unit u_branch
	(
		.pc_i          (ex_pc),
		.rs1_data_i    (ex_rs1_data),
		.rs2_data_i    (ex_rs2_data),
		.imm_i         (ex_decoded.imm),
		.funct3_i      (ex_decoded.funct3),
		.branch_kind_i (ex_control.branch_kind),
		.taken_o       (ex_taken),
		.target_o      (ex_target)
	);

	ex_mem_regs u_ex_mem
	(
		.clk          (clk),
		.rst          (rst),
		.load_i       (load_i),
		.halt_i       (ex_halt),
		.pc_i         (ex_pc),
		.rd_i         (ex_decoded.rd),
		.control_i    (ex_control),
		.alu_result_i (ex_alu_result),
		.taken_i      (ex_taken),
		.target_i     (ex_target),
		.ex_mem_o     (ex_mem_o)
	);

endmodule : id_ex_pipe

`default_nettype wire

//--- tb_id_ex_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module tb_id_ex_pipe;
	import rv32i_types::*;
	import rv32i_ctrl_pkg::*;

	localparam logic [6:0] op_custom = 7'b0001011; // Unsupported opcode that decodes as a no-op.

	typedef struct packed {
		ex_mem_t rec;
		logic    result_known;
	} expect_t;

	logic      clk;
	logic      rst;
	logic      load_i;
	logic      bubble_i;
	logic      halt_i;
	rv32i_word pc_i;
	rv32i_word instruction_i;
	rv32i_word rs1_data_i;
	rv32i_word rs2_data_i;
	ex_mem_t   ex_mem_o;

	expect_t expected_q[$];
	logic    loaded_edge;
	int      errors;
	int      checks;
	int      records;

	id_ex_pipe DUT
	(
		.clk           (clk),
		.rst           (rst),
		.load_i        (load_i),
		.bubble_i      (bubble_i),
		.halt_i        (halt_i),
		.pc_i          (pc_i),
		.instruction_i (instruction_i),
		.rs1_data_i    (rs1_data_i),
		.rs2_data_i    (rs2_data_i),
		.ex_mem_o      (ex_mem_o)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// ------------------------------------------------------------
	// Reference model
	// ------------------------------------------------------------
	function automatic rv32i_word alu_ref(input logic [2:0] f3, input logic alt,
		input rv32i_word a, input rv32i_word b);
		case (f3)
			3'b000:  return alt ? a - b : a + b;
			3'b001:  return a << b[4:0];
			3'b010:  return {31'd0, $signed(a) < $signed(b)};
			3'b011:  return {31'd0, a < b};
			3'b100:  return a ^ b;
			3'b101:  return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'b110:  return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic branch_ref(input logic [2:0] f3, input rv32i_word a,
		input rv32i_word b);
		case (f3)
			3'b000:  return a == b;
			3'b001:  return a != b;
			3'b100:  return $signed(a) < $signed(b);
			3'b101:  return $signed(a) >= $signed(b);
			3'b110:  return a < b;
			3'b111:  return a >= b;
			default: return 1'b0;
		endcase
	endfunction

	function automatic expect_t model_record(input rv32i_word pc, input rv32i_word instr,
		input rv32i_word rs1, input rv32i_word rs2, input logic halt, input logic bubble);
		expect_t   e;
		logic [2:0] f3;
		rv32i_word i_imm;
		rv32i_word b_imm;
		rv32i_word u_imm;
		rv32i_word j_imm;
		e = '0;
		e.rec.pc = pc;
		e.rec.halt = halt;
		e.result_known = 1'b1;
		if (bubble)
			return e; // Squashed slot with a zero result.
		f3 = instr[14:12];
		e.rec.rd = instr[11:7];
		i_imm = {{20{instr[31]}}, instr[31:20]};
		b_imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
		u_imm = {instr[31:12], 12'h000};
		j_imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
		case (instr[6:0])
			op_reg:
			begin
				e.rec.result = alu_ref(f3, instr[30], rs1, rs2);
				e.rec.reg_write = 1'b1;
			end
			op_imm:
			begin
				e.rec.result = alu_ref(f3, (f3 == 3'b101) && instr[30], rs1, i_imm);
				e.rec.reg_write = 1'b1;
			end
			op_lui:
			begin
				e.rec.result = u_imm;
				e.rec.reg_write = 1'b1;
			end
			op_auipc:
			begin
				e.rec.result = pc + u_imm;
				e.rec.reg_write = 1'b1;
			end
			op_jal, op_jalr:
			begin
				e.rec.result = pc + 32'd4;
				e.rec.reg_write = 1'b1;
				e.rec.redirect = 1'b1;
				if (instr[6:0] == op_jal)
					e.rec.redirect_pc = pc + j_imm;
				else
					e.rec.redirect_pc = (rs1 + i_imm) & ~32'd1;
			end
			op_br:
			begin
				e.rec.redirect = branch_ref(f3, rs1, rs2);
				e.rec.redirect_pc = pc + b_imm;
				e.result_known = 1'b0;
			end
			default: e.result_known = 1'b0;
		endcase
		if (e.rec.rd == 5'd0)
			e.rec.reg_write = 1'b0;
		return e;
	endfunction

	// ------------------------------------------------------------
	// Checking
	// ------------------------------------------------------------
	task automatic check_value(input string name, input rv32i_word got, input rv32i_word exp);
		checks++;
		assert (got === exp)
		else
		begin
			errors++;
			$display("Fail at %0t: %s expected %h, got %h", $time, name, exp, got);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		checks++;
		assert (got === exp)
		else
		begin
			errors++;
			$display("Fail at %0t: %s expected %b, got %b", $time, name, exp, got);
		end
	endtask

	task automatic compare_record(input ex_mem_t got, input expect_t exp);
		records++;
		check_value("ex_mem_o.pc", got.pc, exp.rec.pc);
		check_value("ex_mem_o.rd", 32'(got.rd), 32'(exp.rec.rd));
		check_flag("ex_mem_o.reg_write", got.reg_write, exp.rec.reg_write);
		check_flag("ex_mem_o.redirect", got.redirect, exp.rec.redirect);
		check_flag("ex_mem_o.halt", got.halt, exp.rec.halt);
		if (exp.result_known)
			check_value("ex_mem_o.result", got.result, exp.rec.result);
		if (exp.rec.redirect)
			check_value("ex_mem_o.redirect_pc", got.redirect_pc, exp.rec.redirect_pc);
	endtask

	always @(posedge clk)
	begin
		if (rst)
		begin
			expected_q.delete(); // ID/EX reset state keeps halt.
			expected_q.push_back(model_record('0, '0, '0, '0, halt_i, 1'b1));
			loaded_edge = 1'b0;
		end
		else if (load_i)
		begin
			expected_q.push_back(model_record(pc_i, instruction_i, rs1_data_i, rs2_data_i,
				halt_i, bubble_i));
			loaded_edge = 1'b1;
		end
		else
			loaded_edge = 1'b0;
	end

	always @(negedge clk)
	begin
		if (loaded_edge && expected_q.size() > 1)
			compare_record(ex_mem_o, expected_q.pop_front());
	end

	stall_holds: assert property (@(posedge clk) disable iff (rst) !load_i |=> $stable(ex_mem_o))
	else
	begin
		errors++;
		$display("Stall at %0t: ex_mem_o changed while load_i was low.", $time);
	end

	x0_never_written: assert property (@(posedge clk) ex_mem_o.reg_write |-> ex_mem_o.rd != 5'd0)
	else
	begin
		errors++;
		$display("At %0t: reg_write is set for a write to x0.", $time);
	end

	// ------------------------------------------------------------
	// Stimulus
	// ------------------------------------------------------------
	function automatic rv32i_word random_instr();
		rv32i_word w;
		logic [2:0] f3;
		logic [2:0] pick;
		w = $urandom;
		f3 = w[14:12];
		pick = 3'($urandom_range(0, 7));
		case (pick)
			3'd0:
			begin
				w[6:0] = op_reg;
				w[31:25] = ((f3 == 3'b000 || f3 == 3'b101) && w[30]) ? 7'h20 : 7'h00;
			end
			3'd1:
			begin
				w[6:0] = op_imm;
				if (f3 == 3'b001)
					w[31:25] = 7'h00;
				else if (f3 == 3'b101)
					w[31:25] = w[30] ? 7'h20 : 7'h00;
			end
			3'd2: w[6:0] = op_lui;
			3'd3: w[6:0] = op_auipc;
			3'd4: w[6:0] = op_jal;
			3'd5:
			begin
				w[6:0] = op_jalr;
				w[14:12] = 3'b000;
			end
			3'd6:
			begin
				w[6:0] = op_br;
				pick = 3'($urandom_range(0, 5));
				w[14:12] = (pick < 3'd2) ? pick : pick + 3'd2; // Skips reserved 010 and 011.
			end
			default: w[6:0] = op_custom;
		endcase
		return w;
	endfunction

	task automatic present_random(input logic load);
		load_i = load;
		instruction_i = random_instr();
		pc_i = $urandom;
		pc_i[1:0] = 2'b00;
		rs1_data_i = $urandom;
		rs2_data_i = ($urandom_range(0, 3) == 0) ? rs1_data_i : $urandom; // Hits equal compares.
		bubble_i = ($urandom_range(0, 7) == 0);
		halt_i = ($urandom_range(0, 15) == 0);
	endtask

	initial
	begin
		int        stall_left;
		int        waited;
		rv32i_word last_pc;
		void'($urandom(32'hc667_f124));
		errors = 0;
		checks = 0;
		records = 0;
		loaded_edge = 1'b0;
		rst = 1'b1;
		load_i = 1'b1;
		bubble_i = 1'b0;
		halt_i = 1'b1; // Held through reset.
		pc_i = '0;
		instruction_i = '0;
		rs1_data_i = '0;
		rs2_data_i = '0;
		repeat (2) @(posedge clk);
		#1;
		rst = 1'b0;
		check_flag("ex_mem_o.reg_write", ex_mem_o.reg_write, 1'b0);
		check_flag("ex_mem_o.redirect", ex_mem_o.redirect, 1'b0);
		check_flag("ex_mem_o.halt", ex_mem_o.halt, 1'b1);
		present_random(1'b1);
		// Halt with an unsupported opcode and a live rd.
		instruction_i = {20'h12345, 5'd7, op_custom};
		halt_i = 1'b1;
		bubble_i = 1'b0;
		@(posedge clk);
		#1;
		present_random(1'b1);
		@(posedge clk);
		#1;
		repeat (4)
		begin
			present_random(1'b0);
			@(posedge clk);
			#1;
		end
		stall_left = 0;
		for (int i = 0; i < 400; i++)
		begin
			if (stall_left == 0 && $urandom_range(0, 15) == 0)
				stall_left = $urandom_range(2, 5);
			present_random(stall_left == 0);
			if (stall_left > 0)
				stall_left--;
			@(posedge clk);
			#1;
		end
		// ------------------------------------------------------------
		// Drain the records still in flight
		// ------------------------------------------------------------
		present_random(1'b1);
		last_pc = pc_i;
		waited = 0;
		while (ex_mem_o.pc !== last_pc && waited < 20)
		begin
			@(posedge clk);
			#1;
			present_random(1'b1);
			waited++;
		end
		if (ex_mem_o.pc !== last_pc)
		begin
			errors++;
			$display("Timeout: the last record never reached ex_mem_o.");
		end
		@(negedge clk);
		#1;
		$display("Errors: %0d, checks: %0d, records: %0d", errors, checks, records);
		if (errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- id_ex_pipe.f
rv32i_types.sv
rv32i_ctrl_pkg.sv
id_decode.sv
id_ex_regs.sv
ex_alu.sv
ex_branch_unit.sv
ex_mem_regs.sv
id_ex_pipe.sv
tb_id_ex_pipe.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_id_ex_pipe
FILELIST  ?= id_ex_pipe.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST)))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "Test completed successfully" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@echo "Simulation PASSED"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
